// File: rtl/cache_bank_pkg.sv
`default_nettype none

package cache_bank_pkg;

    // default geometry, the top level may override SETS and WAYS
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;
    parameter int SETS   = 16;
    parameter int WAYS   = 4;

    // address split: | tag | index | byte offset |
    parameter int OFFSET_W = $clog2(DATA_W / 8);
    parameter int INDEX_W  = $clog2(SETS);
    parameter int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic [DATA_W-1:0]       data_t;
    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [INDEX_W-1:0]      set_idx_t;
    typedef logic [WAYS-1:0]         way_mask_t;
    typedef logic [$clog2(WAYS)-1:0] way_idx_t;
    typedef logic [1:0]              rrpv_t;

    // SRRIP re-reference prediction values
    parameter rrpv_t RRPV_MAX    = 2'd3;
    parameter rrpv_t RRPV_INSERT = 2'd2;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITEBACK,
        S_FILL_REQ,
        S_FILL_WAIT,
        S_UPDATE,
        S_RESPOND
    } bank_state_e;

endpackage

`default_nettype wire

// File: rtl/lookup_if.sv
`timescale 1ns/10ps
`default_nettype none

interface lookup_if #(
    parameter int SETS = cache_bank_pkg::SETS,
    parameter int WAYS = cache_bank_pkg::WAYS
);
    import cache_bank_pkg::*;

    localparam int IDX_W  = $clog2(SETS);
    localparam int WAY_W  = $clog2(WAYS);
    localparam int TAGL_W = ADDR_W - IDX_W - OFFSET_W;

    // controller side
    logic [IDX_W-1:0]  set_idx;
    logic [TAGL_W-1:0] tag;
    logic              lookup;
    logic              update;
    logic              install;
    logic              set_dirty;
    logic              clr_dirty;

    // tag store side
    logic [WAYS-1:0]   hit_mask;
    logic [WAY_W-1:0]  victim_way;
    logic              victim_dirty;
    logic [TAGL_W-1:0] victim_tag;

    modport ctrl (
        output set_idx, tag, lookup, update, install, set_dirty, clr_dirty,
        input  hit_mask, victim_way, victim_dirty, victim_tag
    );

    modport store (
        input  set_idx, tag, lookup, update, install, set_dirty, clr_dirty,
        output hit_mask, victim_way, victim_dirty, victim_tag
    );

endinterface

`default_nettype wire

// File: rtl/srrip_victim_select.sv
`timescale 1ns/10ps
`default_nettype none

module srrip_victim_select #(
    parameter int WAYS = cache_bank_pkg::WAYS
) (
    input  cache_bank_pkg::rrpv_t    i_rrpv [WAYS],
    input  logic [WAYS-1:0]          i_valid,
    input  logic [WAYS-1:0]          i_hit_mask,
    output logic [$clog2(WAYS)-1:0]  o_victim_way,
    output cache_bank_pkg::rrpv_t    o_rrpv_next [WAYS]
);
    import cache_bank_pkg::*;

    localparam int WAY_W = $clog2(WAYS);

    rrpv_t max_rrpv;
    logic  hit;

    // -------------------------------------------------------------------------
    // victim choice
    // -------------------------------------------------------------------------
    always_comb begin
        max_rrpv = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (i_rrpv[w] > max_rrpv) begin
                max_rrpv = i_rrpv[w];
            end
        end
        // scan downwards so the lowest matching way wins
        o_victim_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (i_rrpv[w] == max_rrpv) begin
                o_victim_way = WAY_W'(w);
            end
        end
        // any free way beats the SRRIP choice
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!i_valid[w]) begin
                o_victim_way = WAY_W'(w);
            end
        end
    end

    // -------------------------------------------------------------------------
    // re-reference update
    // -------------------------------------------------------------------------
    assign hit = |i_hit_mask;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            o_rrpv_next[w] = i_rrpv[w];
            if (hit) begin
                if (i_hit_mask[w]) begin
                    o_rrpv_next[w] = '0;
                end
            end else if (o_victim_way == WAY_W'(w)) begin
                o_rrpv_next[w] = RRPV_INSERT;
            end else if (i_valid[w] && i_rrpv[w] != RRPV_MAX) begin
                o_rrpv_next[w] = i_rrpv[w] + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/data_store.sv
`timescale 1ns/10ps
`default_nettype none

module data_store #(
    parameter int SETS = cache_bank_pkg::SETS,
    parameter int WAYS = cache_bank_pkg::WAYS
) (
    input  logic                     i_clk,
    input  logic [$clog2(SETS)-1:0]  i_set,
    input  logic [$clog2(WAYS)-1:0]  i_way,
    input  logic                     i_rd,
    input  logic                     i_wr,
    input  cache_bank_pkg::data_t    i_wdata,
    output cache_bank_pkg::data_t    o_rdata
);

    // one word per line, SETS x WAYS entries
    logic [$bits(i_wdata)-1:0] mem [SETS][WAYS];

    // read data holds until the next read
    always_ff @(posedge i_clk) begin
        if (i_wr) begin
            mem[i_set][i_way] <= i_wdata;
        end
        if (i_rd) begin
            o_rdata <= mem[i_set][i_way];
        end
    end

endmodule

`default_nettype wire

// File: rtl/tag_store.sv
`timescale 1ns/10ps
`default_nettype none

module tag_store #(
    parameter int SETS = cache_bank_pkg::SETS,
    parameter int WAYS = cache_bank_pkg::WAYS
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    lookup_if.store                  lk,
    output cache_bank_pkg::rrpv_t    o_rrpv [WAYS],
    output logic [WAYS-1:0]          o_valid,
    input  logic [$clog2(WAYS)-1:0]  i_victim_way,
    input  cache_bank_pkg::rrpv_t    i_rrpv_next [WAYS]
);
    import cache_bank_pkg::*;

    localparam int IDX_W  = $clog2(SETS);
    localparam int WAY_W  = $clog2(WAYS);
    localparam int TAGL_W = ADDR_W - IDX_W - OFFSET_W;

    logic [TAGL_W-1:0] tag_mem [SETS][WAYS];
    logic [WAYS-1:0]   valid_q [SETS];
    logic [WAYS-1:0]   dirty_q [SETS];
    rrpv_t             rrpv_q  [SETS][WAYS];
    logic [IDX_W-1:0]  rd_set;
    logic [WAYS-1:0]   sel_way;

    // parallel compare over the registered set
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            lk.hit_mask[w] = valid_q[rd_set][w] && (tag_mem[rd_set][w] == lk.tag);
            o_rrpv[w]      = rrpv_q[rd_set][w];
        end
    end

    // way touched by the dirty strobes: victim on install, hit way otherwise
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            sel_way[w] = lk.install ? (i_victim_way == WAY_W'(w)) : lk.hit_mask[w];
        end
    end

    assign o_valid         = valid_q[rd_set];
    assign lk.victim_way   = i_victim_way;
    assign lk.victim_dirty = valid_q[rd_set][i_victim_way] && dirty_q[rd_set][i_victim_way];
    assign lk.victim_tag   = tag_mem[rd_set][i_victim_way];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_set <= '0;
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                for (int w = 0; w < WAYS; w++) begin
                    rrpv_q[s][w] <= RRPV_MAX;
                end
            end
        end else begin
            if (lk.lookup) begin
                rd_set <= lk.set_idx;
            end
            if (lk.update) begin
                for (int w = 0; w < WAYS; w++) begin
                    rrpv_q[rd_set][w] <= i_rrpv_next[w];
                end
            end
            if (lk.install) begin
                valid_q[rd_set][i_victim_way] <= 1'b1;
            end
            for (int w = 0; w < WAYS; w++) begin
                if (sel_way[w] && lk.set_dirty) begin
                    dirty_q[rd_set][w] <= 1'b1;
                end else if (sel_way[w] && lk.clr_dirty) begin
                    dirty_q[rd_set][w] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (lk.install) begin
            tag_mem[rd_set][i_victim_way] <= lk.tag;
        end
    end

    // a tag lives in at most one way of a set
    a_hit_onehot: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(lk.hit_mask)
    );

endmodule

`default_nettype wire

// File: rtl/bank_controller.sv
`timescale 1ns/10ps
`default_nettype none

module bank_controller #(
    parameter int SETS = cache_bank_pkg::SETS,
    parameter int WAYS = cache_bank_pkg::WAYS
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_req_valid,
    output logic                      o_req_ready,
    input  cache_bank_pkg::req_op_e   i_req_op,
    input  cache_bank_pkg::addr_t     i_req_addr,
    input  cache_bank_pkg::data_t     i_req_wdata,
    output logic                      o_rsp_valid,
    input  logic                      i_rsp_ready,
    output cache_bank_pkg::data_t     o_rsp_rdata,
    output logic                      o_mem_req_valid,
    input  logic                      i_mem_req_ready,
    output logic                      o_mem_we,
    output cache_bank_pkg::addr_t     o_mem_addr,
    output cache_bank_pkg::data_t     o_mem_wdata,
    input  logic                      i_mem_rvalid,
    output logic                      o_mem_rready,
    input  cache_bank_pkg::data_t     i_mem_rdata,
    lookup_if.ctrl                    lk,
    output logic [$clog2(SETS)-1:0]   o_data_set,
    output logic [$clog2(WAYS)-1:0]   o_data_way,
    output logic                      o_data_rd,
    output logic                      o_data_wr,
    output cache_bank_pkg::data_t     o_data_wdata,
    input  cache_bank_pkg::data_t     i_data_rdata
);
    import cache_bank_pkg::*;

    localparam int IDX_W  = $clog2(SETS);
    localparam int WAY_W  = $clog2(WAYS);
    localparam int TAGL_W = ADDR_W - IDX_W - OFFSET_W;

    bank_state_e       state_q;
    bank_state_e       state_d;
    req_op_e           op_q;
    addr_t             addr_q;
    data_t             wdata_q;
    data_t             rdata_q;
    logic [IDX_W-1:0]  set_q;
    logic [TAGL_W-1:0] tag_q;
    logic [WAY_W-1:0]  hit_way;
    logic              hit;
    logic              accept;

    assign set_q  = addr_q[OFFSET_W +: IDX_W];
    assign tag_q  = addr_q[ADDR_W-1 -: TAGL_W];
    assign accept = i_req_valid && (state_q == S_IDLE);

    // hit mask is one-hot, so a plain OR-encode is enough
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (lk.hit_mask[w]) begin
                hit_way = hit_way | WAY_W'(w);
            end
        end
    end
    assign hit = |lk.hit_mask;

    // -------------------------------------------------------------------------
    // request FSM
    // -------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:      if (i_req_valid) state_d = S_LOOKUP;
            S_LOOKUP: begin
                if (hit) begin
                    state_d = S_UPDATE;
                end else if (lk.victim_dirty) begin
                    state_d = S_WRITEBACK;
                end else if (op_q == OP_READ) begin
                    state_d = S_FILL_REQ;
                end else begin
                    state_d = S_UPDATE;
                end
            end
            S_WRITEBACK: begin
                if (i_mem_req_ready) begin
                    state_d = (op_q == OP_READ) ? S_FILL_REQ : S_UPDATE;
                end
            end
            S_FILL_REQ:  if (i_mem_req_ready) state_d = S_FILL_WAIT;
            S_FILL_WAIT: if (i_mem_rvalid) state_d = S_UPDATE;
            S_UPDATE:    state_d = S_RESPOND;
            S_RESPOND:   if (i_rsp_ready) state_d = S_IDLE;
            default:     state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request payload and response word
    always_ff @(posedge i_clk) begin
        if (accept) begin
            op_q    <= i_req_op;
            addr_q  <= i_req_addr;
            wdata_q <= i_req_wdata;
        end
        if (state_q == S_FILL_WAIT && i_mem_rvalid) begin
            rdata_q <= i_mem_rdata;
        end else if (state_q == S_UPDATE) begin
            if (op_q == OP_WRITE) begin
                rdata_q <= wdata_q;
            end else if (hit) begin
                rdata_q <= i_data_rdata;
            end
        end
    end

    // tag store strobes
    assign lk.set_idx   = (state_q == S_IDLE) ? i_req_addr[OFFSET_W +: IDX_W] : set_q;
    assign lk.tag       = tag_q;
    assign lk.lookup    = accept;
    assign lk.update    = (state_q == S_UPDATE);
    assign lk.install   = lk.update && !hit;
    assign lk.set_dirty = lk.update && (op_q == OP_WRITE);
    assign lk.clr_dirty = lk.install && (op_q == OP_READ);

    // data array: read hit or victim way in lookup, write on update
    assign o_data_set   = set_q;
    assign o_data_way   = hit ? hit_way : lk.victim_way;
    assign o_data_rd    = (state_q == S_LOOKUP);
    assign o_data_wr    = lk.update && ((op_q == OP_WRITE) || !hit);
    assign o_data_wdata = (op_q == OP_WRITE) ? wdata_q : rdata_q;

    // DRAM channels, the victim word stays on the data store output
    assign o_mem_req_valid = (state_q == S_WRITEBACK) || (state_q == S_FILL_REQ);
    assign o_mem_we        = (state_q == S_WRITEBACK);
    assign o_mem_addr      = o_mem_we ? {lk.victim_tag, set_q, {OFFSET_W{1'b0}}}
                                      : {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign o_mem_wdata     = i_data_rdata;
    assign o_mem_rready    = (state_q == S_FILL_WAIT);

    assign o_req_ready = (state_q == S_IDLE);
    assign o_rsp_valid = (state_q == S_RESPOND);
    assign o_rsp_rdata = rdata_q;

    a_rsp_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_rdata)
    );

    a_mem_req_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_mem_req_valid && !i_mem_req_ready |=>
            o_mem_req_valid && $stable({o_mem_we, o_mem_addr, o_mem_wdata})
    );

endmodule

`default_nettype wire

// File: rtl/cache_bank_top.sv
`timescale 1ns/10ps
`default_nettype none

module cache_bank_top #(
    parameter int SETS = cache_bank_pkg::SETS,
    parameter int WAYS = cache_bank_pkg::WAYS
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    // processing element request / response
    input  logic                      i_req_valid,
    output logic                      o_req_ready,
    input  cache_bank_pkg::req_op_e   i_req_op,
    input  cache_bank_pkg::addr_t     i_req_addr,
    input  cache_bank_pkg::data_t     i_req_wdata,
    output logic                      o_rsp_valid,
    input  logic                      i_rsp_ready,
    output cache_bank_pkg::data_t     o_rsp_rdata,
    // DRAM port
    output logic                      o_mem_req_valid,
    input  logic                      i_mem_req_ready,
    output logic                      o_mem_we,
    output cache_bank_pkg::addr_t     o_mem_addr,
    output cache_bank_pkg::data_t     o_mem_wdata,
    input  logic                      i_mem_rvalid,
    output logic                      o_mem_rready,
    input  cache_bank_pkg::data_t     i_mem_rdata
);
    import cache_bank_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);

    lookup_if #(.SETS(SETS), .WAYS(WAYS)) lookup ();

    // replacement state of the looked-up set
    rrpv_t            rrpv      [WAYS];
    rrpv_t            rrpv_next [WAYS];
    logic [WAYS-1:0]  valid_mask;
    logic [WAY_W-1:0] victim_way;

    // data array port
    logic [IDX_W-1:0] data_set;
    logic [WAY_W-1:0] data_way;
    logic             data_rd;
    logic             data_wr;
    data_t            data_wdata;
    data_t            data_rdata;

    bank_controller #(.SETS(SETS), .WAYS(WAYS)) u_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .i_req_op        (i_req_op),
        .i_req_addr      (i_req_addr),
        .i_req_wdata     (i_req_wdata),
        .o_rsp_valid     (o_rsp_valid),
        .i_rsp_ready     (i_rsp_ready),
        .o_rsp_rdata     (o_rsp_rdata),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .o_mem_we        (o_mem_we),
        .o_mem_addr      (o_mem_addr),
        .o_mem_wdata     (o_mem_wdata),
        .i_mem_rvalid    (i_mem_rvalid),
        .o_mem_rready    (o_mem_rready),
        .i_mem_rdata     (i_mem_rdata),
        .lk              (lookup.ctrl),
        .o_data_set      (data_set),
        .o_data_way      (data_way),
        .o_data_rd       (data_rd),
        .o_data_wr       (data_wr),
        .o_data_wdata    (data_wdata),
        .i_data_rdata    (data_rdata)
    );

    tag_store #(.SETS(SETS), .WAYS(WAYS)) u_tags (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .lk           (lookup.store),
        .o_rrpv       (rrpv),
        .o_valid      (valid_mask),
        .i_victim_way (victim_way),
        .i_rrpv_next  (rrpv_next)
    );

    srrip_victim_select #(.WAYS(WAYS)) u_victim (
        .i_rrpv       (rrpv),
        .i_valid      (valid_mask),
        .i_hit_mask   (lookup.hit_mask),
        .o_victim_way (victim_way),
        .o_rrpv_next  (rrpv_next)
    );

    data_store #(.SETS(SETS), .WAYS(WAYS)) u_data (
        .i_clk   (i_clk),
        .i_set   (data_set),
        .i_way   (data_way),
        .i_rd    (data_rd),
        .i_wr    (data_wr),
        .i_wdata (data_wdata),
        .o_rdata (data_rdata)
    );

endmodule

`default_nettype wire

// File: include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// background pattern of the DRAM model
localparam data_t MEM_PATTERN = 32'h5A3C_96E1;

// byte address to the address of its word
function automatic addr_t word_addr(input addr_t addr);
    return addr & ~addr_t'((1 << OFFSET_W) - 1);
endfunction

// DRAM contents of a word that was never written back
function automatic data_t ref_word(input addr_t addr);
    return data_t'(word_addr(addr)) ^ MEM_PATTERN;
endfunction

// compare one value, stop the run at the first mismatch
task automatic check_value(
    input string       name,
    input logic [31:0] got,
    input logic [31:0] exp
);
    if (got !== exp) begin
        $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        $display("TEST FAIL");
        $fatal(1, "value mismatch on %s", name);
    end
endtask

`endif

// File: test/cache_bank_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cache_bank_tb;
    import cache_bank_pkg::*;

    `include "tb_checks.svh"

    localparam int N_DIRECTED   = 18;
    localparam int N_RANDOM     = 300;
    localparam int RESET_CYCLES = 16;
    localparam int WATCHDOG_CYC = RESET_CYCLES + 200 * (N_DIRECTED + N_RANDOM);

    logic    i_clk = 1'b0;
    logic    i_rst_n;
    logic    i_req_valid;
    logic    o_req_ready;
    req_op_e i_req_op;
    addr_t   i_req_addr;
    data_t   i_req_wdata;
    logic    o_rsp_valid;
    logic    i_rsp_ready;
    data_t   o_rsp_rdata;
    logic    o_mem_req_valid;
    logic    i_mem_req_ready;
    logic    o_mem_we;
    addr_t   o_mem_addr;
    data_t   o_mem_wdata;
    logic    i_mem_rvalid;
    logic    o_mem_rready;
    data_t   i_mem_rdata;

    // golden map, DRAM model and traffic bookkeeping
    data_t golden   [addr_t];
    data_t dram_mem [addr_t];
    data_t exp_q    [$];
    logic  rand_stall  = 1'b0;
    int    cycle       = 0;
    int    n_issued    = 0;
    int    n_accepted  = 0;
    int    n_responses = 0;
    int    n_mem_rd    = 0;
    int    n_mem_wr    = 0;
    int    acc_cycle   = 0;
    int    rsp_cycle   = 0;
    addr_t last_rd_addr;
    addr_t last_wb_addr;

    cache_bank_top #(.SETS(SETS), .WAYS(WAYS)) u_cache_bank_top (.*);

    always #4 i_clk = ~i_clk;

    // -----------------------------------------------------------------------
    // reference model and helpers
    // -----------------------------------------------------------------------
    function automatic data_t expected_word(input addr_t addr);
        if (golden.exists(word_addr(addr))) begin
            return golden[word_addr(addr)];
        end
        return ref_word(addr);
    endfunction

    function automatic data_t dram_word(input addr_t addr);
        if (dram_mem.exists(word_addr(addr))) begin
            return dram_mem[word_addr(addr)];
        end
        return ref_word(addr);
    endfunction

    function automatic addr_t make_addr(input int set, input int tag);
        return (addr_t'(tag) << (INDEX_W + OFFSET_W)) | (addr_t'(set) << OFFSET_W);
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_idle_outputs();
        check_value("o_rsp_valid", 32'(o_rsp_valid), 32'd0);
        check_value("o_mem_req_valid", 32'(o_mem_req_valid), 32'd0);
        check_value("o_mem_rready", 32'(o_mem_rready), 32'd0);
        check_value("o_req_ready", 32'(o_req_ready), 32'd1);
    endtask

    // holds the request until the bank takes it
    task automatic issue_request(input req_op_e op, input addr_t addr, input data_t wdata);
        i_req_valid = 1'b1;
        i_req_op    = op;
        i_req_addr  = addr;
        i_req_wdata = wdata;
        n_issued++;
        @(posedge i_clk);
        while (!o_req_ready) begin
            @(posedge i_clk);
        end
        #1;
        i_req_valid = 1'b0;
    endtask

    task automatic wait_responses();
        @(negedge i_clk);
        while (n_responses != n_issued) begin
            @(negedge i_clk);
        end
        @(posedge i_clk);
        #1;
    endtask

    // -----------------------------------------------------------------------
    // stimulus
    // -----------------------------------------------------------------------
    initial begin : stimulus
        addr_t   a;
        int      rd0;
        int      wr0;
        int      gap;
        req_op_e op;
        void'($urandom(22720));
        i_rst_n     = 1'b0;
        i_req_valid = 1'b0;
        i_req_op    = OP_READ;
        i_req_addr  = '0;
        i_req_wdata = '0;
        repeat (RESET_CYCLES) begin
            @(negedge i_clk);
            check_idle_outputs();
        end
        @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check_idle_outputs();
        @(posedge i_clk);
        #1;

        // cold read, one fill from the aligned word
        a   = make_addr(3, 'h21) | addr_t'(2);
        rd0 = n_mem_rd;
        issue_request(OP_READ, a, '0);
        wait_responses();
        check_value("dram read count", n_mem_rd - rd0, 1);
        check_value("fill o_mem_addr", last_rd_addr, word_addr(a));

        // write allocate, then hit
        a   = make_addr(3, 'h22);
        rd0 = n_mem_rd;
        issue_request(OP_WRITE, a, 32'hCAFE_0001);
        issue_request(OP_READ, a, '0);
        wait_responses();
        check_value("dram read count", n_mem_rd - rd0, 0);

        // overflow one set with dirty lines
        wr0 = n_mem_wr;
        for (int t = 0; t < WAYS + 2; t++) begin
            issue_request(OP_WRITE, make_addr(9, 'h40 + t), $urandom);
        end
        wait_responses();
        check_value("dram write-back count", n_mem_wr - wr0, 2);
        // second spill evicts the second tag written
        rd0 = n_mem_rd;
        a   = make_addr(9, 'h41);
        check_value("write-back o_mem_addr", last_wb_addr, a);
        issue_request(OP_READ, a, '0);
        wait_responses();
        check_value("dram read count", n_mem_rd - rd0, 1);
        check_value("fill o_mem_addr", last_rd_addr, a);
        for (int t = 0; t < WAYS + 2; t++) begin
            issue_request(OP_READ, make_addr(9, 'h40 + t), '0);
        end
        wait_responses();

        // repeated read hits with fixed latency
        a = make_addr(7, 'h30);
        issue_request(OP_READ, a, '0);
        wait_responses();
        rd0 = n_mem_rd;
        wr0 = n_mem_wr;
        issue_request(OP_READ, a, '0);
        wait_responses();
        check_value("dram read count", n_mem_rd - rd0, 0);
        check_value("dram write count", n_mem_wr - wr0, 0);
        check_value("hit response latency", rsp_cycle - acc_cycle, 3);

        // random mix over four sets, eight tags each
        rand_stall = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            op = ($urandom_range(0, 1) == 1) ? OP_WRITE : OP_READ;
            a  = make_addr($urandom_range(0, 3), $urandom_range(0, 7));
            a  = a | addr_t'($urandom_range(0, 3));
            issue_request(op, a, $urandom);
            gap = $urandom_range(0, 2);
            if (gap > 0) begin
                repeat (gap) @(posedge i_clk);
                #1;
            end
        end
        wait_responses();
        rand_stall = 1'b0;

        if (n_accepted == n_issued && n_responses == n_issued && exp_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("request count %0d does not match %0d responses", n_issued, n_responses);
            $display("TEST FAIL");
            $fatal(1, "request and response counts differ");
        end
    end

    initial begin : rsp_ready_driver
        i_rsp_ready = 1'b1;
        forever begin
            @(posedge i_clk);
            #1;
            i_rsp_ready = rand_stall ? ($urandom_range(0, 2) != 0) : 1'b1;
        end
    end

    // -----------------------------------------------------------------------
    // accepted requests and response comparison
    // -----------------------------------------------------------------------
    initial begin : track_and_compare
        addr_t wa;
        data_t exp_word;
        forever begin
            @(posedge i_clk);
            cycle++;
            if (i_rst_n && o_rsp_valid && i_rsp_ready) begin
                if (exp_q.size() == 0) begin
                    stop_with_error("response arrived with no request outstanding");
                end else begin
                    exp_word = exp_q.pop_front();
                    check_value("o_rsp_rdata", o_rsp_rdata, exp_word);
                    n_responses++;
                    rsp_cycle = cycle;
                end
            end
            if (i_rst_n && i_req_valid && o_req_ready) begin
                if (exp_q.size() != 0) begin
                    stop_with_error("request accepted before the previous response");
                end else begin
                    wa = word_addr(i_req_addr);
                    if (i_req_op == OP_WRITE) begin
                        golden[wa] = i_req_wdata;
                    end
                    exp_q.push_back(expected_word(wa));
                    n_accepted++;
                    acc_cycle = cycle;
                end
            end
        end
    end

    // sparse DRAM with random stalls on both channels
    initial begin : dram_responder
        logic  fill_busy;
        addr_t fill_addr;
        int    fill_delay;
        fill_busy       = 1'b0;
        fill_addr       = '0;
        fill_delay      = 0;
        i_mem_req_ready = 1'b0;
        i_mem_rvalid    = 1'b0;
        i_mem_rdata     = '0;
        forever begin
            @(posedge i_clk);
            if (i_rst_n && i_mem_rvalid && o_mem_rready) begin
                fill_busy = 1'b0;
            end
            if (i_rst_n && o_mem_req_valid && i_mem_req_ready) begin
                if (o_mem_we) begin
                    check_value("o_mem_wdata", o_mem_wdata, expected_word(o_mem_addr));
                    dram_mem[word_addr(o_mem_addr)] = o_mem_wdata;
                    last_wb_addr = o_mem_addr;
                    n_mem_wr++;
                end else begin
                    fill_busy    = 1'b1;
                    fill_addr    = o_mem_addr;
                    fill_delay   = rand_stall ? $urandom_range(0, 3) : 0;
                    last_rd_addr = o_mem_addr;
                    n_mem_rd++;
                end
            end
            #1;
            i_mem_req_ready = rand_stall ? ($urandom_range(0, 3) != 0) : 1'b1;
            if (fill_busy && fill_delay == 0) begin
                i_mem_rvalid = 1'b1;
                i_mem_rdata  = dram_word(fill_addr);
            end else begin
                i_mem_rvalid = 1'b0;
                if (fill_busy) begin
                    fill_delay--;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge i_clk);
        stop_with_error("watchdog expired before all requests completed");
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
rtl/cache_bank_pkg.sv
rtl/lookup_if.sv
rtl/srrip_victim_select.sv
rtl/data_store.sv
rtl/tag_store.sv
rtl/bank_controller.sv
rtl/cache_bank_top.sv
test/cache_bank_tb.sv

// File: Makefile
TOP := cache_bank_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir $(OBJ) -o V$(TOP)

# the log decides pass or fail, the binary's own status is not trusted alone
run: compile
	./$(OBJ)/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJ) sim.log
